// File: agc_defs.svh
`ifndef AGC_DEFS_SVH
`define AGC_DEFS_SVH

// Data path widths
`define AGC_NCHAN         8
`define AGC_SAMPLE_BITS   12
`define AGC_OUT_BITS      5
`define AGC_SCALE_BITS    17
`define AGC_SCALE_FRAC    12   // Scale is Q5.12
`define AGC_OFFSET_BITS   16
`define AGC_PIPE_STAGES   2

// Measurement window
`define AGC_WINDOW_CYCLES 256
`define AGC_WINDOW_SHIFT  11   // 256 clocks x 8 channels

// Loop targets and steps
`define AGC_START_SCALE   1500
`define AGC_START_OFFSET  0
`define AGC_TARGET_MS     16
`define AGC_MS_ERR        2
`define AGC_SCALE_DELTA   30
`define AGC_OFFSET_DELTA  25
`define AGC_OFFSET_ERR    5
`define AGC_SCALE_MIN     300
`define AGC_SCALE_MAX     130000
`define AGC_OFFSET_LIMIT  1000
`define AGC_BOOT_CYCLES   31

// Register map
`define AGC_ADDR_CTRL     8'h00
`define AGC_ADDR_MS       8'h04
`define AGC_ADDR_GT       8'h08
`define AGC_ADDR_LT       8'h0C
`define AGC_ADDR_SCALE    8'h10
`define AGC_ADDR_OFFSET   8'h14

// Control write bits and status bits
`define AGC_CMD_START     0
`define AGC_CMD_CLEAR     2
`define AGC_CMD_LOAD      8
`define AGC_CMD_APPLY     10
`define AGC_STAT_DONE     1

`endif

// File: agc_pkg.sv
`include "agc_defs.svh"

package agc_pkg;

    typedef logic signed [`AGC_SAMPLE_BITS-1:0] sample_t;
    typedef logic signed [`AGC_OUT_BITS-1:0]    out_sample_t;
    typedef logic        [`AGC_SCALE_BITS-1:0]  scale_t;     // Unsigned fixed point
    typedef logic signed [`AGC_OFFSET_BITS-1:0] offset_t;
    typedef logic        [23:0]                 sq_sum_t;
    typedef logic        [11:0]                 count_t;
    typedef logic        [7:0]                  bus_addr_t;
    typedef logic        [31:0]                 bus_data_t;

    typedef struct packed {
        scale_t  scale;
        offset_t offset;
    } agc_gain_t;

    typedef struct packed {
        sq_sum_t sq_sum;
        count_t  gt;
        count_t  lt;
    } chan_stats_t;

    typedef struct packed {
        sq_sum_t ms;    // Mean square over all channels
        count_t  gt;
        count_t  lt;
        logic    done;
    } agc_stats_t;

    typedef struct packed {
        logic      cyc;
        logic      we;
        bus_addr_t addr;
        bus_data_t data;
    } agc_bus_req_t;

    typedef struct packed {
        logic      ack;
        bus_data_t data;
    } agc_bus_rsp_t;

    typedef enum logic [3:0] {
        BOOT, WRITE_GAIN, LOAD, APPLY, CLEAR, START, POLL, READ_STATS, CALC
    } loop_state_e;

    typedef enum logic [1:0] {
        SEND, WAIT, PROCESS
    } bus_phase_e;

endpackage

// File: agc_register_block.sv
`timescale 1ns/1ps
`include "agc_defs.svh"

module agc_register_block (
    input  logic                  aclk,
    input  logic                  wb_rst_i,
    input  agc_pkg::agc_bus_req_t bus_req_i,
    input  agc_pkg::agc_stats_t   stats_i,
    output agc_pkg::agc_bus_rsp_t bus_rsp_o,
    output agc_pkg::agc_gain_t    gain_o,
    output logic                  window_run_o,
    output logic                  window_end_o,
    output logic                  stats_clear_o
);

    localparam int win_bits = $clog2(`AGC_WINDOW_CYCLES);
    localparam agc_pkg::agc_gain_t start_gain = '{
        scale:  agc_pkg::scale_t'(`AGC_START_SCALE),
        offset: agc_pkg::offset_t'(`AGC_START_OFFSET)
    };

    agc_pkg::agc_gain_t pending_gain;
    agc_pkg::agc_gain_t staged_gain;
    agc_pkg::bus_data_t rd_data;
    logic [win_bits-1:0] win_cnt;
    logic                accept;

    assign accept = bus_req_i.cyc && !bus_rsp_o.ack;   // One ack per transfer

    // Read mux
    always_comb begin
        rd_data = '0;
        case (bus_req_i.addr)
            `AGC_ADDR_CTRL: begin
                rd_data[`AGC_STAT_DONE] = stats_i.done;
                rd_data[0]              = window_run_o;
            end
            `AGC_ADDR_MS:     rd_data = agc_pkg::bus_data_t'(stats_i.ms);
            `AGC_ADDR_GT:     rd_data = agc_pkg::bus_data_t'(stats_i.gt);
            `AGC_ADDR_LT:     rd_data = agc_pkg::bus_data_t'(stats_i.lt);
            `AGC_ADDR_SCALE:  rd_data = agc_pkg::bus_data_t'(gain_o.scale);
            `AGC_ADDR_OFFSET: rd_data = agc_pkg::bus_data_t'(gain_o.offset); // Sign extended
            default:          rd_data = '0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            bus_rsp_o     <= '0;
            pending_gain  <= start_gain;
            staged_gain   <= start_gain;
            gain_o        <= start_gain;
            window_run_o  <= 1'b0;
            window_end_o  <= 1'b0;
            stats_clear_o <= 1'b0;
            win_cnt       <= '0;
        end else begin
            bus_rsp_o.ack <= accept;
            window_end_o  <= 1'b0;
            stats_clear_o <= 1'b0;

            //////////////////////////////
            // Window timer
            if (window_run_o) begin
                win_cnt <= win_cnt + 1'b1;
                if (win_cnt == win_bits'(`AGC_WINDOW_CYCLES - 1)) begin
                    window_run_o <= 1'b0;
                    window_end_o <= 1'b1;
                end
            end

            //////////////////////////////
            // Bus writes
            if (accept && bus_req_i.we) begin
                case (bus_req_i.addr)
                    `AGC_ADDR_CTRL: begin
                        if (bus_req_i.data[`AGC_CMD_CLEAR]) stats_clear_o <= 1'b1;
                        if (bus_req_i.data[`AGC_CMD_START]) begin
                            window_run_o <= 1'b1;
                            win_cnt      <= '0;
                        end
                        if (bus_req_i.data[`AGC_CMD_LOAD])  staged_gain <= pending_gain;
                        if (bus_req_i.data[`AGC_CMD_APPLY]) gain_o <= staged_gain;
                    end
                    `AGC_ADDR_SCALE:
                        pending_gain.scale <= bus_req_i.data[`AGC_SCALE_BITS-1:0];
                    `AGC_ADDR_OFFSET:
                        pending_gain.offset <= bus_req_i.data[`AGC_OFFSET_BITS-1:0];
                    default: ;
                endcase
            end

            if (accept && !bus_req_i.we) bus_rsp_o.data <= rd_data; // Valid with ack
        end
    end

endmodule

// File: agc_channel.sv
`timescale 1ns/1ps
`include "agc_defs.svh"

module agc_channel (
    input  logic                   aclk,
    input  logic                   wb_rst_i,
    input  agc_pkg::sample_t       sample_i,
    input  agc_pkg::agc_gain_t     gain_i,
    input  logic                   window_run_i,
    input  logic                   stats_clear_i,
    output agc_pkg::out_sample_t   sample_o,
    output agc_pkg::chan_stats_t   stats_o
);

    localparam int out_max = 2 ** (`AGC_OUT_BITS - 1) - 1;
    localparam int out_min = -(2 ** (`AGC_OUT_BITS - 1));

    logic signed [`AGC_OFFSET_BITS:0]                    biased_q;
    logic signed [`AGC_OFFSET_BITS+`AGC_SCALE_BITS+1:0]  product;
    logic signed [`AGC_OFFSET_BITS+`AGC_SCALE_BITS+1:0]  shifted;
    agc_pkg::out_sample_t                                sat_val;
    logic        [2*`AGC_OUT_BITS-1:0]                   out_sq;
    logic        [`AGC_PIPE_STAGES-1:0]                  run_dly;

    // Scale is unsigned, so give it a zero sign bit
    assign product = biased_q * $signed({1'b0, gain_i.scale});
    assign shifted = product >>> `AGC_SCALE_FRAC;
    assign out_sq  = sample_o * sample_o;

    // Clamp to the trigger range
    always_comb begin
        if (shifted > out_max) begin
            sat_val = agc_pkg::out_sample_t'(out_max);
        end else if (shifted < out_min) begin
            sat_val = agc_pkg::out_sample_t'(out_min);
        end else begin
            sat_val = shifted[`AGC_OUT_BITS-1:0];
        end
    end

    //////////////////////////////
    // Two stage data path
    always_ff @(posedge aclk) begin
        biased_q <= sample_i + gain_i.offset;    // Stage one
        sample_o <= sat_val;                     // Stage two
    end

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            run_dly <= '0;
            stats_o <= '0;
        end else begin
            run_dly <= {run_dly[`AGC_PIPE_STAGES-2:0], window_run_i};
            if (stats_clear_i) begin
                stats_o <= '0;
            end else if (run_dly[`AGC_PIPE_STAGES-1]) begin
                // Flag lines up with sample_o here
                stats_o.sq_sum <= stats_o.sq_sum + out_sq;
                if (sample_o > 0) stats_o.gt <= stats_o.gt + 1'b1;
                if (sample_o < 0) stats_o.lt <= stats_o.lt + 1'b1;
            end
        end
    end

endmodule

// File: agc_stats_collector.sv
`timescale 1ns/1ps
`include "agc_defs.svh"

module agc_stats_collector (
    input  logic                                       aclk,
    input  logic                                       wb_rst_i,
    input  agc_pkg::chan_stats_t [`AGC_NCHAN-1:0]      chan_stats_i,
    input  logic                                       window_end_i,
    input  logic                                       stats_clear_i,
    output agc_pkg::agc_stats_t                        stats_o
);

    logic [`AGC_PIPE_STAGES-1:0] end_dly;
    agc_pkg::sq_sum_t            sq_total;
    agc_pkg::count_t             gt_total;
    agc_pkg::count_t             lt_total;

    // Adder tree over the channels
    always_comb begin
        sq_total = '0;
        gt_total = '0;
        lt_total = '0;
        for (int i = 0; i < `AGC_NCHAN; i++) begin
            sq_total = sq_total + chan_stats_i[i].sq_sum;
            gt_total = gt_total + chan_stats_i[i].gt;
            lt_total = lt_total + chan_stats_i[i].lt;
        end
    end

    //////////////////////////////
    // Latch once the channel pipes drain
    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            end_dly <= '0;
            stats_o <= '0;
        end else begin
            end_dly <= {end_dly[`AGC_PIPE_STAGES-2:0], window_end_i};
            if (stats_clear_i) begin
                stats_o <= '0;               // Drops done too
            end else if (end_dly[`AGC_PIPE_STAGES-1]) begin
                stats_o.ms   <= sq_total >> `AGC_WINDOW_SHIFT;
                stats_o.gt   <= gt_total;
                stats_o.lt   <= lt_total;
                stats_o.done <= 1'b1;
            end
        end
    end

endmodule

// File: agc_control_loop.sv
`timescale 1ns/1ps
`include "agc_defs.svh"

module agc_control_loop (
    input  logic                  aclk,
    input  logic                  wb_rst_i,
    input  agc_pkg::agc_bus_rsp_t bus_rsp_i,
    output agc_pkg::agc_bus_req_t bus_req_o
);

    localparam int boot_bits = $clog2(`AGC_BOOT_CYCLES + 1);

    agc_pkg::loop_state_e  state;
    agc_pkg::bus_phase_e   phase;
    agc_pkg::agc_bus_req_t req_next;
    agc_pkg::bus_data_t    rsp_q;
    logic [boot_bits-1:0]  boot_cnt;
    logic [2:0]            idx;     // Word within a multi-access step

    // Values read back from the target
    agc_pkg::sq_sum_t      ms_q;
    agc_pkg::count_t       gt_q;
    agc_pkg::count_t       lt_q;
    agc_pkg::scale_t       scale_q;
    agc_pkg::offset_t      offset_q;

    // Values to write next
    agc_pkg::scale_t       new_scale;
    agc_pkg::offset_t      new_offset;

    //////////////////////////////
    // Request for the current step
    always_comb begin
        req_next     = '0;
        req_next.cyc = 1'b1;
        req_next.we  = 1'b1;
        req_next.addr = `AGC_ADDR_CTRL;
        case (state)
            agc_pkg::WRITE_GAIN: begin
                if (idx == 3'd0) begin
                    req_next.addr = `AGC_ADDR_SCALE;
                    req_next.data = agc_pkg::bus_data_t'(new_scale);
                end else begin
                    req_next.addr = `AGC_ADDR_OFFSET;
                    req_next.data = agc_pkg::bus_data_t'(new_offset);
                end
            end
            agc_pkg::LOAD:  req_next.data[`AGC_CMD_LOAD]  = 1'b1;
            agc_pkg::APPLY: req_next.data[`AGC_CMD_APPLY] = 1'b1;
            agc_pkg::CLEAR: req_next.data[`AGC_CMD_CLEAR] = 1'b1;
            agc_pkg::START: req_next.data[`AGC_CMD_START] = 1'b1;
            agc_pkg::POLL:  req_next.we = 1'b0;                   // Status read
            agc_pkg::READ_STATS: begin
                req_next.we   = 1'b0;
                req_next.addr = `AGC_ADDR_MS + {idx, 2'b00};      // MS, GT, LT, scale, offset
            end
            default: req_next = '0;
        endcase
    end

    //////////////////////////////
    // Correction FSM
    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            state      <= agc_pkg::BOOT;
            phase      <= agc_pkg::SEND;
            bus_req_o  <= '0;
            rsp_q      <= '0;
            boot_cnt   <= boot_bits'(`AGC_BOOT_CYCLES - 1);
            idx        <= '0;
            ms_q       <= '0;
            gt_q       <= '0;
            lt_q       <= '0;
            scale_q    <= agc_pkg::scale_t'(`AGC_START_SCALE);
            offset_q   <= agc_pkg::offset_t'(`AGC_START_OFFSET);
            new_scale  <= agc_pkg::scale_t'(`AGC_START_SCALE);
            new_offset <= agc_pkg::offset_t'(`AGC_START_OFFSET);
        end else begin
            case (phase)
                agc_pkg::SEND: begin
                    if (state == agc_pkg::BOOT) begin
                        if (boot_cnt != '0) boot_cnt <= boot_cnt - 1'b1;
                        else state <= agc_pkg::WRITE_GAIN;   // Start gain already staged
                    end else if (state == agc_pkg::CALC) begin
                        // Fixed steps, held at the cutoffs
                        new_scale <= scale_q;
                        if (ms_q > `AGC_TARGET_MS + `AGC_MS_ERR) begin
                            if (scale_q > `AGC_SCALE_MIN)
                                new_scale <= scale_q - agc_pkg::scale_t'(`AGC_SCALE_DELTA);
                        end else if (ms_q < `AGC_TARGET_MS - `AGC_MS_ERR) begin
                            if (scale_q < `AGC_SCALE_MAX)
                                new_scale <= scale_q + agc_pkg::scale_t'(`AGC_SCALE_DELTA);
                        end

                        new_offset <= offset_q;
                        if (gt_q > lt_q + `AGC_OFFSET_ERR) begin
                            if (offset_q > -`AGC_OFFSET_LIMIT)
                                new_offset <= offset_q - agc_pkg::offset_t'(`AGC_OFFSET_DELTA);
                        end else if (lt_q > gt_q + `AGC_OFFSET_ERR) begin
                            if (offset_q < `AGC_OFFSET_LIMIT)
                                new_offset <= offset_q + agc_pkg::offset_t'(`AGC_OFFSET_DELTA);
                        end
                        state <= agc_pkg::WRITE_GAIN;
                    end else begin
                        bus_req_o <= req_next;
                        phase     <= agc_pkg::WAIT;
                    end
                end

                agc_pkg::WAIT: begin
                    if (bus_rsp_i.ack) begin
                        bus_req_o.cyc <= 1'b0;     // Release in the ack cycle
                        rsp_q         <= bus_rsp_i.data;
                        phase         <= agc_pkg::PROCESS;
                    end
                end

                default: begin
                    phase <= agc_pkg::SEND;
                    case (state)
                        agc_pkg::WRITE_GAIN: begin
                            if (idx == 3'd1) begin
                                idx   <= '0;
                                state <= agc_pkg::LOAD;
                            end else begin
                                idx <= 3'd1;
                            end
                        end
                        agc_pkg::LOAD:  state <= agc_pkg::APPLY;
                        agc_pkg::APPLY: state <= agc_pkg::CLEAR;
                        agc_pkg::CLEAR: state <= agc_pkg::START;
                        agc_pkg::START: state <= agc_pkg::POLL;
                        agc_pkg::POLL: begin
                            if (rsp_q[`AGC_STAT_DONE]) begin
                                idx   <= '0;
                                state <= agc_pkg::READ_STATS;
                            end                         // Otherwise poll again
                        end
                        agc_pkg::READ_STATS: begin
                            case (idx)
                                3'd0:    ms_q     <= agc_pkg::sq_sum_t'(rsp_q);
                                3'd1:    gt_q     <= agc_pkg::count_t'(rsp_q);
                                3'd2:    lt_q     <= agc_pkg::count_t'(rsp_q);
                                3'd3:    scale_q  <= agc_pkg::scale_t'(rsp_q);
                                default: offset_q <= agc_pkg::offset_t'(rsp_q);
                            endcase
                            if (idx == 3'd4) begin
                                idx   <= '0;
                                state <= agc_pkg::CALC;
                            end else begin
                                idx <= idx + 1'b1;
                            end
                        end
                        default: state <= agc_pkg::BOOT;
                    endcase
                end
            endcase
        end
    end

endmodule

// File: trigger_agc_top.sv
`timescale 1ns/1ps
`include "agc_defs.svh"

module trigger_agc_top (
    input  logic                                   aclk,
    input  logic                                   wb_rst_i,
    input  agc_pkg::sample_t     [`AGC_NCHAN-1:0]  dat_i,
    output agc_pkg::out_sample_t [`AGC_NCHAN-1:0]  dat_o,
    output agc_pkg::agc_gain_t                     gain_o
);

    agc_pkg::agc_bus_req_t                  bus_req;
    agc_pkg::agc_bus_rsp_t                  bus_rsp;
    agc_pkg::agc_stats_t                    stats;
    agc_pkg::chan_stats_t [`AGC_NCHAN-1:0]  chan_stats;
    logic                                   window_run;
    logic                                   window_end;
    logic                                   stats_clear;

    agc_register_block u_regs (
        .aclk          (aclk),
        .wb_rst_i      (wb_rst_i),
        .bus_req_i     (bus_req),
        .stats_i       (stats),
        .bus_rsp_o     (bus_rsp),
        .gain_o        (gain_o),        // Active gain, shared by all channels
        .window_run_o  (window_run),
        .window_end_o  (window_end),
        .stats_clear_o (stats_clear)
    );

    for (genvar i = 0; i < `AGC_NCHAN; i++) begin : g_chan
        agc_channel u_chan (
            .aclk          (aclk),
            .wb_rst_i      (wb_rst_i),
            .sample_i      (dat_i[i]),
            .gain_i        (gain_o),
            .window_run_i  (window_run),
            .stats_clear_i (stats_clear),
            .sample_o      (dat_o[i]),
            .stats_o       (chan_stats[i])
        );
    end

    agc_stats_collector u_collector (
        .aclk          (aclk),
        .wb_rst_i      (wb_rst_i),
        .chan_stats_i  (chan_stats),
        .window_end_i  (window_end),
        .stats_clear_i (stats_clear),
        .stats_o       (stats)
    );

    agc_control_loop u_loop (
        .aclk      (aclk),
        .wb_rst_i  (wb_rst_i),
        .bus_rsp_i (bus_rsp),
        .bus_req_o (bus_req)
    );

endmodule

// File: tb_agc_assert.sv
`timescale 1ns/1ps

module tb_agc_assert (
    input  logic                  aclk,
    input  logic                  wb_rst_i,
    input  agc_pkg::loop_state_e  state_i,
    input  agc_pkg::agc_bus_req_t bus_req_i,
    input  agc_pkg::agc_bus_rsp_t bus_rsp_i
);

    int fail_count = 0;

    // Master keeps the request up until the target answers
    cyc_hold: assert property (@(posedge aclk) disable iff (wb_rst_i)
        bus_req_i.cyc && !bus_rsp_i.ack |=> bus_req_i.cyc)
    else begin
        fail_count++;
        $error("bus request dropped before its ack");
    end

    // Target answers the clock after a new request, for one cycle only
    ack_single: assert property (@(posedge aclk) disable iff (wb_rst_i)
        $rose(bus_req_i.cyc) |=> bus_rsp_i.ack ##1 !bus_rsp_i.ack)
    else begin
        fail_count++;
        $error("bus ack late or held longer than one cycle");
    end

    // Quiet bus while the boot delay runs
    boot_idle: assert property (@(posedge aclk) disable iff (wb_rst_i)
        state_i == agc_pkg::BOOT |-> !bus_req_i.cyc)
    else begin
        fail_count++;
        $error("bus request issued during boot");
    end

endmodule

// File: tb_agc_checker.sv
`timescale 1ns/1ps
`include "agc_defs.svh"

module tb_agc_checker (
    input  logic                                  aclk,
    input  logic                                  wb_rst_i,
    input  agc_pkg::sample_t     [`AGC_NCHAN-1:0] dat_i,
    input  agc_pkg::out_sample_t [`AGC_NCHAN-1:0] dat_o,
    input  agc_pkg::agc_gain_t                    gain_i,
    input  int                                    scale_dir_i,
    input  int                                    offset_dir_i,
    output int                                    moves_o,
    output int                                    xfer_errors_o,
    output int                                    gain_errors_o
);

    localparam agc_pkg::agc_gain_t start_gain = '{
        scale:  agc_pkg::scale_t'(`AGC_START_SCALE),
        offset: agc_pkg::offset_t'(`AGC_START_OFFSET)
    };

    agc_pkg::sample_t [`AGC_NCHAN-1:0] din_d1;
    agc_pkg::sample_t [`AGC_NCHAN-1:0] din_d2;
    agc_pkg::agc_gain_t                gain_d1;
    agc_pkg::agc_gain_t                gain_d2;
    int                                hist;
    int                                run_cycles;

    // (sample + offset) * scale, Q12 shift, clamp to the 5-bit range
    function automatic int expected_out(input agc_pkg::sample_t s, input agc_pkg::agc_gain_t g);
        longint acc;
        longint hi;
        hi  = (64'sd1 <<< (`AGC_OUT_BITS - 1)) - 1;
        acc = (longint'(s) + longint'(g.offset)) * longint'(g.scale);
        acc = acc >>> `AGC_SCALE_FRAC;
        if (acc > hi) acc = hi;
        if (acc < -hi - 1) acc = -hi - 1;
        return int'(acc);
    endfunction

    function automatic int next_scale(input agc_pkg::scale_t old, input int dir);
        int cur;
        cur = int'(old);
        if (dir < 0 && cur > `AGC_SCALE_MIN) cur = cur - `AGC_SCALE_DELTA;
        else if (dir > 0 && cur < `AGC_SCALE_MAX) cur = cur + `AGC_SCALE_DELTA;
        return cur;
    endfunction

    function automatic int next_offset(input agc_pkg::offset_t old, input int dir);
        int cur;
        cur = old;                                  // Sign extends
        if (dir < 0 && cur > -`AGC_OFFSET_LIMIT) cur = cur - `AGC_OFFSET_DELTA;
        else if (dir > 0 && cur < `AGC_OFFSET_LIMIT) cur = cur + `AGC_OFFSET_DELTA;
        return cur;
    endfunction

    task automatic check_outputs;
        int want;
        for (int ch = 0; ch < `AGC_NCHAN; ch++) begin
            want = expected_out(din_d2[ch], gain_d2);
            if (dat_o[ch] !== agc_pkg::out_sample_t'(want)) begin
                xfer_errors_o++;
                $display("FAILED at %0t: channel %0d input %0d gave %0d, expected %0d",
                         $time, ch, $signed(din_d2[ch]), $signed(dat_o[ch]), want);
            end
        end
    endtask

    task automatic check_move;
        int want_scale;
        int want_offset;
        want_scale  = next_scale(gain_d1.scale, scale_dir_i);
        want_offset = next_offset(gain_d1.offset, offset_dir_i);
        moves_o <= moves_o + 1;
        if (int'(gain_i.scale) != want_scale || int'(gain_i.offset) != want_offset) begin
            gain_errors_o++;
            $display("FAILED at %0t: gain moved to %0d/%0d from %0d/%0d, expected %0d/%0d",
                     $time, gain_i.scale, gain_i.offset, gain_d1.scale, gain_d1.offset,
                     want_scale, want_offset);
        end
        if (gain_i.scale < `AGC_SCALE_MIN || gain_i.scale > `AGC_SCALE_MAX ||
            gain_i.offset < -`AGC_OFFSET_LIMIT || gain_i.offset > `AGC_OFFSET_LIMIT) begin
            gain_errors_o++;
            $display("FAILED at %0t: gain %0d/%0d outside its limits",
                     $time, gain_i.scale, gain_i.offset);
        end
    endtask

    //////////////////////////////
    // All inputs sampled before the edge updates them
    always @(posedge aclk) begin
        if (!wb_rst_i) begin
            if (run_cycles == `AGC_BOOT_CYCLES && gain_i !== start_gain) begin
                gain_errors_o++;
                $display("FAILED at %0t: gain after boot is %0d/%0d, expected %0d/%0d",
                         $time, gain_i.scale, gain_i.offset,
                         start_gain.scale, start_gain.offset);
            end
            if (hist >= 2 && gain_i === gain_d1 && gain_d1 === gain_d2) check_outputs();
            if (hist >= 1 && gain_i !== gain_d1) check_move();
            run_cycles <= run_cycles + 1;
        end else begin
            run_cycles <= 0;
        end
        din_d1  <= dat_i;
        din_d2  <= din_d1;
        gain_d1 <= gain_i;
        gain_d2 <= gain_d1;
        if (hist < 2) hist <= hist + 1;
    end

endmodule

// File: tb_trigger_agc.sv
`timescale 1ns/1ps
`include "agc_defs.svh"

module tb_trigger_agc;

    localparam int reset_cycles = 16;
    localparam int nrows        = 5;

    typedef struct packed {
        int   amp;
        int   dc;
        logic noise;
        int   corrections;
        int   scale_dir;    // Expected direction of each move
        int   offset_dir;
    } row_t;

    localparam row_t rows [nrows] = '{
        //  amp    dc  noise  corr  scale offset
        '{1800,     0, 1'b0,    3,   -1,    0},    // Loud, saturates both ways
        '{   4,     0, 1'b1,    3,    1,    0},    // Quiet
        '{  40,   200, 1'b0,    3,   -1,   -1},
        '{  40,  -200, 1'b1,    4,   -1,    1},
        '{  40,  1500, 1'b0,   35,   -1,   -1}     // Scale runs down into its floor
    };

    logic                                  aclk;
    logic                                  wb_rst_i;
    agc_pkg::sample_t     [`AGC_NCHAN-1:0] dat_i;
    agc_pkg::out_sample_t [`AGC_NCHAN-1:0] dat_o;
    agc_pkg::agc_gain_t                    gain_o;
    int                                    scale_dir;
    int                                    offset_dir;
    int                                    changes;
    int                                    xfer_errors;
    int                                    gain_errors;
    int                                    tick;
    integer                                seed;

    trigger_agc_top u_trigger_agc_top (
        .aclk     (aclk),
        .wb_rst_i (wb_rst_i),
        .dat_i    (dat_i),
        .dat_o    (dat_o),
        .gain_o   (gain_o)
    );

    tb_agc_checker u_checker (
        .aclk          (aclk),
        .wb_rst_i      (wb_rst_i),
        .dat_i         (dat_i),
        .dat_o         (dat_o),
        .gain_i        (gain_o),
        .scale_dir_i   (scale_dir),
        .offset_dir_i  (offset_dir),
        .moves_o       (changes),
        .xfer_errors_o (xfer_errors),
        .gain_errors_o (gain_errors)
    );

    bind agc_control_loop tb_agc_assert u_assert (
        .aclk      (aclk),
        .wb_rst_i  (wb_rst_i),
        .state_i   (state),
        .bus_req_i (bus_req_o),
        .bus_rsp_i (bus_rsp_i)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    // Square wave with the phase flipped per channel, so counts stay balanced
    task automatic drive_step(input row_t row);
        agc_pkg::sample_t [`AGC_NCHAN-1:0] next;
        int v;
        for (int ch = 0; ch < `AGC_NCHAN; ch++) begin
            v = (((tick + ch) % 2) == 1) ? row.amp : -row.amp;
            v = v + row.dc;
            if (row.noise) v = v + ($random(seed) % 2);
            next[ch] = agc_pkg::sample_t'(v);
        end
        dat_i <= next;
        tick++;
        @(posedge aclk);
    endtask

    //////////////////////////////
    // Watchdog
    initial begin
        int limit;
        limit = reset_cycles + `AGC_BOOT_CYCLES;
        for (int r = 0; r < nrows; r++) begin
            limit = limit + rows[r].corrections * (`AGC_WINDOW_CYCLES + 200);
        end
        repeat (limit) @(posedge aclk);
        $display("Timeout after %0d cycles, the gain stopped moving", limit);
        $display("Simulation FAILED");
        $finish;
    end

    //////////////////////////////
    // Stimulus table loop
    initial begin
        int target;
        int asserts;
        seed       = 51993;
        tick       = 0;
        wb_rst_i   = 1'b1;
        dat_i      = '0;
        scale_dir  = 0;
        offset_dir = 0;
        repeat (reset_cycles) @(posedge aclk);
        wb_rst_i <= 1'b0;
        repeat (`AGC_BOOT_CYCLES) @(posedge aclk);    // Zero input through boot

        for (int r = 0; r < nrows; r++) begin
            scale_dir  <= rows[r].scale_dir;
            offset_dir <= rows[r].offset_dir;
            target = changes + rows[r].corrections;
            // Each row switch follows an apply, so every window sees one row only
            while (changes < target) drive_step(rows[r]);
        end

        asserts = u_trigger_agc_top.u_loop.u_assert.fail_count;
        $display("Errors: transfer %0d, gain %0d, assertion %0d",
                 xfer_errors, gain_errors, asserts);
        if (xfer_errors + gain_errors + asserts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+.
agc_pkg.sv
agc_register_block.sv
agc_channel.sv
agc_stats_collector.sv
agc_control_loop.sv
trigger_agc_top.sv
tb_agc_assert.sv
tb_agc_checker.sv
tb_trigger_agc.sv
